// ==== dsp_route_pkg.sv ====
package dsp_route_pkg;

   localparam int SAMPLE_W    = 14;           // converter sample width
   localparam int SUM_W       = 18;           // tree node width, headroom for 16 leaves
   localparam int SEL_W       = 4;            // source number width

   localparam int N_SLOTS     = 8;            // processing slots
   localparam int N_DIRECT    = N_SLOTS + 2;  // slots plus two generators
   localparam int N_CONSUMERS = N_SLOTS + 4;  // slots, two scopes, two pwm
   localparam int N_SOURCES   = 2**SEL_W;     // numbered sources incl. zero codes
   localparam int N_LEAVES    = 16;           // adder tree leaves, 10 and up are zero
   localparam int SUM_LATENCY = 5;            // direct input to dac output, in edges

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic        [SEL_W-1:0]    src_sel_t;
   typedef logic        [1:0]          out_mask_t;  // bit 0 dac1, bit 1 dac2
   typedef logic signed [SUM_W-1:0]    dac_sum_t;

   // source numbering, slots take 0..7
   localparam src_sel_t SRC_ASG1  = 4'd8;
   localparam src_sel_t SRC_ASG2  = 4'd9;
   localparam src_sel_t SRC_ADC1  = 4'd10;
   localparam src_sel_t SRC_ADC2  = 4'd11;
   localparam src_sel_t SRC_DAC1  = 4'd12;
   localparam src_sel_t SRC_DAC2  = 4'd13;
   localparam src_sel_t SRC_SPARE = 4'd14;    // no second quadrature, reads zero
   localparam src_sel_t SRC_NONE  = 4'd15;    // switches a consumer off

   // consumer numbering, slots take 0..7
   localparam int CON_SCOPE1 = 8;
   localparam int CON_SCOPE2 = 9;
   localparam int CON_PWM0   = 10;
   localparam int CON_PWM1   = 11;

   localparam int MASK_DAC1 = 0;              // mask bit per dac
   localparam int MASK_DAC2 = 1;

   // full-scale limits, clamp targets of the summers
   localparam sample_t  SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
   localparam sample_t  SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};
   localparam dac_sum_t SUM_MAX    = dac_sum_t'(SAMPLE_MAX);
   localparam dac_sum_t SUM_MIN    = dac_sum_t'(SAMPLE_MIN);

   // selection after reset: pwm off, scope 2 on adc2, the rest on adc1
   localparam src_sel_t [N_CONSUMERS-1:0] INPUT_SEL_RESET =
      {SRC_NONE, SRC_NONE, SRC_ADC2, SRC_ADC1, {N_SLOTS{SRC_ADC1}}};

endpackage

// ==== dsp_bus_pkg.sv ====
package dsp_bus_pkg;

   typedef logic [31:0] bus_addr_t;
   typedef logic [31:0] bus_data_t;

   localparam int OFS_W   = 16;   // register offset, low address bits
   localparam int TGT_LSB = 16;   // target number starts here
   localparam int TGT_W   = 4;

   typedef logic [OFS_W-1:0] reg_ofs_t;
   typedef logic [TGT_W-1:0] target_t;

   typedef struct packed {
      bus_addr_t addr;
      bus_data_t wdata;
      logic      wen;    // one-cycle write strobe
      logic      ren;    // one-cycle read strobe
   } bus_req_t;

   typedef struct packed {
      bus_data_t rdata;  // valid together with ack
      logic      ack;
      logic      err;
   } bus_rsp_t;

   // register map of the hub
   localparam reg_ofs_t OFS_INPUT_SEL  = 16'h0000;
   localparam reg_ofs_t OFS_OUTPUT_SEL = 16'h0004;
   localparam reg_ofs_t OFS_SAT        = 16'h0008;
   localparam reg_ofs_t OFS_SYNC       = 16'h000C;
   localparam reg_ofs_t OFS_SIGNAL     = 16'h0010;

   function automatic reg_ofs_t reg_ofs(bus_addr_t addr);
      return addr[OFS_W-1:0];
   endfunction

   function automatic target_t reg_target(bus_addr_t addr);
      return addr[TGT_LSB +: TGT_W];
   endfunction

endpackage

// ==== dsp_source_mux.sv ====
`timescale 1ns/1ps

module dsp_source_mux (
   input  dsp_route_pkg::sample_t  [dsp_route_pkg::N_SOURCES-1:0]   sources_i,
   input  dsp_route_pkg::src_sel_t [dsp_route_pkg::N_CONSUMERS-1:0] sel_i,
   output dsp_route_pkg::sample_t  [dsp_route_pkg::N_CONSUMERS-1:0] consumer_o
);

   import dsp_route_pkg::*;

   // one selector per consumer, slots first, then scopes and pwm
   always_comb begin
      for (int c = 0; c < N_CONSUMERS; c++) begin
         if (sel_i[c] == SRC_NONE || sel_i[c] == SRC_SPARE) begin
            consumer_o[c] = '0;                    // off or no source behind it
         end else begin
            consumer_o[c] = sources_i[sel_i[c]];
         end
      end
   end

   // the whole selection bank comes out of reset on one edge,
   // a known slot 0 selection thus means all of them must be known
   always_comb begin
      if (!$isunknown(sel_i[0])) begin
         assert (!$isunknown(sel_i))
            else $error("source mux: consumer selection unknown after reset");
      end
   end

endmodule

// ==== dsp_dac_sum.sv ====
`timescale 1ns/1ps

module dsp_dac_sum (
   input  logic                                                clk_i,
   input  logic                                                rstn_i,
   input  dsp_route_pkg::sample_t [dsp_route_pkg::N_DIRECT-1:0] direct_i,
   input  logic                   [dsp_route_pkg::N_DIRECT-1:0] enable_i,
   output dsp_route_pkg::sample_t                              dac_o,
   output logic                                                saturated_o
);

   import dsp_route_pkg::*;

   dac_sum_t [N_LEAVES-1:0]   leaf;     // masked, sign-extended inputs
   dac_sum_t [N_LEAVES/2-1:0] pair_q;   // first stage with sums of pairs
   dac_sum_t [N_LEAVES/4-1:0] lvl1_q;
   dac_sum_t [N_LEAVES/8-1:0] lvl2_q;
   dac_sum_t                  lvl3_q;   // tree root
   dac_sum_t                  sum_q;    // output register ahead of the clamp

   // leaves without a direct source stay zero
   always_comb begin
      leaf = '0;
      for (int k = 0; k < N_DIRECT; k++) begin
         if (enable_i[k]) begin
            leaf[k] = {{(SUM_W-SAMPLE_W){direct_i[k][SAMPLE_W-1]}}, direct_i[k]};
         end
      end
   end

   // five edges from input to sum_q over pairs, three levels and output
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         pair_q <= '0;
         lvl1_q <= '0;
         lvl2_q <= '0;
         lvl3_q <= '0;
         sum_q  <= '0;   // dac sits at zero after reset
      end else begin
         for (int i = 0; i < N_LEAVES/2; i++) begin
            pair_q[i] <= leaf[2*i] + leaf[2*i+1];
         end
         for (int i = 0; i < N_LEAVES/4; i++) begin
            lvl1_q[i] <= pair_q[2*i] + pair_q[2*i+1];
         end
         for (int i = 0; i < N_LEAVES/8; i++) begin
            lvl2_q[i] <= lvl1_q[2*i] + lvl1_q[2*i+1];
         end
         lvl3_q <= lvl2_q[0] + lvl2_q[1];
         sum_q  <= lvl3_q;                  // extra register for slack
      end
   end

   // clamp to 14 bits and flag while clamping
   always_comb begin
      if (sum_q > SUM_MAX) begin
         dac_o       = SAMPLE_MAX;
         saturated_o = 1'b1;
      end else if (sum_q < SUM_MIN) begin
         dac_o       = SAMPLE_MIN;
         saturated_o = 1'b1;
      end else begin
         dac_o       = sum_q[SAMPLE_W-1:0];  // plain truncation when in range
         saturated_o = 1'b0;
      end
   end

   // flag comes with the full-scale value on the side of the root sign
   a_sat_full_scale : assert property (@(posedge clk_i) disable iff (!rstn_i)
      saturated_o |-> (dac_o == (sum_q[SUM_W-1] ? SAMPLE_MIN : SAMPLE_MAX)))
      else $error("dac sum: saturation flag without matching full-scale output");

   // reset zeroes the whole pipe so nothing reaches the dac before it refills
   a_reset_flush : assert property (@(posedge clk_i)
      $rose(rstn_i) |-> (dac_o == '0) [*SUM_LATENCY])
      else $error("dac sum: output not zero right after reset");

endmodule

// ==== dsp_route_regs.sv ====
`timescale 1ns/1ps

module dsp_route_regs (
   input  logic                                                    clk_i,
   input  logic                                                    rstn_i,
   input  dsp_bus_pkg::bus_req_t                                   sys_req_i,
   output dsp_bus_pkg::bus_rsp_t                                   sys_rsp_o,
   input  dsp_route_pkg::sample_t   [dsp_route_pkg::N_SOURCES-1:0]   sources_i,
   input  logic                     [1:0]                            saturated_i,
   output dsp_route_pkg::src_sel_t  [dsp_route_pkg::N_CONSUMERS-1:0] input_sel_o,
   output dsp_route_pkg::out_mask_t [dsp_route_pkg::N_DIRECT-1:0]    output_sel_o,
   output logic                     [dsp_route_pkg::N_SLOTS-1:0]     sync_o
);

   import dsp_route_pkg::*;
   import dsp_bus_pkg::*;

   src_sel_t  [N_CONSUMERS-1:0] input_sel_q;
   out_mask_t [N_DIRECT-1:0]    output_sel_q;
   logic      [N_SLOTS-1:0]     sync_q;
   reg_ofs_t                    ofs;
   target_t                     tgt;
   logic                        tgt_is_consumer;
   logic                        tgt_is_direct;
   bus_data_t                   rdata_d;
   bus_data_t                   rdata_q;
   logic                        ack_q;

   // address split, offset low, target in bits 19:16
   assign ofs             = reg_ofs(sys_req_i.addr);
   assign tgt             = reg_target(sys_req_i.addr);
   assign tgt_is_consumer = int'(tgt) < N_CONSUMERS;
   assign tgt_is_direct   = int'(tgt) < N_DIRECT;

   // config registers, a write lands on the edge that sees the strobe
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         input_sel_q  <= INPUT_SEL_RESET;   // whole bank in one go
         output_sel_q <= '0;                // no direct output on any dac
         sync_q       <= '1;                // all slots running
      end else if (sys_req_i.wen) begin
         case (ofs)
            OFS_INPUT_SEL: begin
               if (tgt_is_consumer) begin
                  input_sel_q[tgt] <= sys_req_i.wdata[SEL_W-1:0];
               end
            end
            OFS_OUTPUT_SEL: begin
               if (tgt_is_direct) begin
                  output_sel_q[tgt] <= sys_req_i.wdata[$bits(out_mask_t)-1:0];
               end
            end
            OFS_SYNC: sync_q <= sys_req_i.wdata[N_SLOTS-1:0];
            default: ;                      // read-only or unmapped, dropped
         endcase
      end
   end

   // read mux
   always_comb begin
      rdata_d = '0;                         // unknown offsets read zero
      case (ofs)
         OFS_INPUT_SEL: begin
            if (tgt_is_consumer) begin
               rdata_d = bus_data_t'(input_sel_q[tgt]);
            end
         end
         OFS_OUTPUT_SEL: begin
            if (tgt_is_direct) begin
               rdata_d = bus_data_t'(output_sel_q[tgt]);
            end
         end
         OFS_SAT:    rdata_d = bus_data_t'(saturated_i);   // bit 1 dac2, bit 0 dac1
         OFS_SYNC:   rdata_d = bus_data_t'(sync_q);
         OFS_SIGNAL: rdata_d = bus_data_t'(unsigned'(sources_i[tgt]));  // zero-extended
         default: ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (sys_req_i.ren) begin
         rdata_q <= rdata_d;                // valid in the ack cycle
      end
   end

   // every strobe gets its ack one edge later, no wait states
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= sys_req_i.wen | sys_req_i.ren;
      end
   end

   assign sys_rsp_o    = '{rdata: rdata_q, ack: ack_q, err: 1'b0};
   assign input_sel_o  = input_sel_q;
   assign output_sel_o = output_sel_q;
   assign sync_o       = sync_q;

   // an ack never shows up without a strobe on the edge before
   a_ack_follows_strobe : assert property (@(posedge clk_i) disable iff (!rstn_i)
      sys_rsp_o.ack |-> $past(sys_req_i.wen || sys_req_i.ren))
      else $error("route regs: acknowledge without a preceding strobe");

endmodule

// ==== red_pitaya_dsp.sv ====
`timescale 1ns/1ps

module red_pitaya_dsp (
   input  logic                                                 clk_i,
   input  logic                                                 rstn_i,
   input  dsp_route_pkg::sample_t                               adc_a_i,
   input  dsp_route_pkg::sample_t                               adc_b_i,
   input  dsp_route_pkg::sample_t                               asg1_i,
   input  dsp_route_pkg::sample_t                               asg2_i,
   output dsp_route_pkg::sample_t                               dac_a_o,
   output dsp_route_pkg::sample_t                               dac_b_o,
   output dsp_route_pkg::sample_t                               scope1_o,
   output dsp_route_pkg::sample_t                               scope2_o,
   output dsp_route_pkg::sample_t                               pwm0_o,
   output dsp_route_pkg::sample_t                               pwm1_o,
   output dsp_route_pkg::sample_t [dsp_route_pkg::N_SLOTS-1:0]   slot_in_o,
   input  dsp_route_pkg::sample_t [dsp_route_pkg::N_SLOTS-1:0]   slot_signal_i,
   input  dsp_route_pkg::sample_t [dsp_route_pkg::N_SLOTS-1:0]   slot_direct_i,
   output logic                   [dsp_route_pkg::N_SLOTS-1:0]   sync_o,
   input  dsp_bus_pkg::bus_req_t                                sys_req_i,
   output dsp_bus_pkg::bus_rsp_t                                sys_rsp_o
);

   import dsp_route_pkg::*;

   sample_t   [N_SOURCES-1:0]   sources;     // everything a consumer can pick
   sample_t   [N_DIRECT-1:0]    direct;      // everything that can reach a dac
   sample_t   [N_CONSUMERS-1:0] consumers;
   src_sel_t  [N_CONSUMERS-1:0] input_sel;
   out_mask_t [N_DIRECT-1:0]    output_sel;
   logic      [N_DIRECT-1:0]    dac1_en;
   logic      [N_DIRECT-1:0]    dac2_en;
   logic                        dac1_sat;
   logic                        dac2_sat;

   // source array, dac outputs loop back as sources 12 and 13
   always_comb begin
      sources                = '0;           // spare and none slots read zero
      sources[N_SLOTS-1:0]   = slot_signal_i;
      sources[SRC_ASG1]      = asg1_i;
      sources[SRC_ASG2]      = asg2_i;
      sources[SRC_ADC1]      = adc_a_i;
      sources[SRC_ADC2]      = adc_b_i;
      sources[SRC_DAC1]      = dac_a_o;
      sources[SRC_DAC2]      = dac_b_o;
   end

   assign direct = {asg2_i, asg1_i, slot_direct_i};   // generators on 8 and 9

   // split the 2-bit masks into one enable vector per dac
   always_comb begin
      for (int k = 0; k < N_DIRECT; k++) begin
         dac1_en[k] = output_sel[k][MASK_DAC1];
         dac2_en[k] = output_sel[k][MASK_DAC2];
      end
   end

   dsp_source_mux u_mux (
      .sources_i  (sources),
      .sel_i      (input_sel),
      .consumer_o (consumers)
   );

   assign slot_in_o = consumers[N_SLOTS-1:0];
   assign scope1_o  = consumers[CON_SCOPE1];
   assign scope2_o  = consumers[CON_SCOPE2];
   assign pwm0_o    = consumers[CON_PWM0];
   assign pwm1_o    = consumers[CON_PWM1];

   dsp_dac_sum u_sum_a (          // dac 1
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .direct_i    (direct),
      .enable_i    (dac1_en),
      .dac_o       (dac_a_o),
      .saturated_o (dac1_sat)
   );

   dsp_dac_sum u_sum_b (          // dac 2
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .direct_i    (direct),
      .enable_i    (dac2_en),
      .dac_o       (dac_b_o),
      .saturated_o (dac2_sat)
   );

   dsp_route_regs u_regs (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .sys_req_i    (sys_req_i),
      .sys_rsp_o    (sys_rsp_o),
      .sources_i    (sources),
      .saturated_i  ({dac2_sat, dac1_sat}),
      .input_sel_o  (input_sel),
      .output_sel_o (output_sel),
      .sync_o       (sync_o)
   );

endmodule

// ==== tb_dsp.sv ====
`timescale 1ns/1ps

module tb_dsp;

   import dsp_route_pkg::*;
   import dsp_bus_pkg::*;

   localparam int ACK_TIMEOUT = 16;   // ack is due one edge after the strobe

   logic                     clk_i;
   logic                     rstn_i;
   sample_t                  adc_a, adc_b;              // converter inputs
   sample_t                  asg1, asg2;                // generator inputs
   sample_t                  dac_a, dac_b;
   sample_t                  scope1, scope2, pwm0, pwm1;
   sample_t [N_SLOTS-1:0]    slot_in;
   sample_t [N_SLOTS-1:0]    slot_signal;
   sample_t [N_SLOTS-1:0]    slot_direct;
   logic    [N_SLOTS-1:0]    sync;
   bus_req_t                 sys_req;
   bus_rsp_t                 sys_rsp;

   out_mask_t [N_DIRECT-1:0] mask_model;   // dac masks as written over the bus
   logic [16:0]              lfsr;         // 17-bit fibonacci with taps 17 and 14
   logic                     timed_out;
   int                       checks;
   int                       mismatches;
   int                       failures;

   red_pitaya_dsp DUT (
      .clk_i         (clk_i),
      .rstn_i        (rstn_i),
      .adc_a_i       (adc_a),
      .adc_b_i       (adc_b),
      .asg1_i        (asg1),
      .asg2_i        (asg2),
      .dac_a_o       (dac_a),
      .dac_b_o       (dac_b),
      .scope1_o      (scope1),
      .scope2_o      (scope2),
      .pwm0_o        (pwm0),
      .pwm1_o        (pwm1),
      .slot_in_o     (slot_in),
      .slot_signal_i (slot_signal),
      .slot_direct_i (slot_direct),
      .sync_o        (sync),
      .sys_req_i     (sys_req),
      .sys_rsp_o     (sys_rsp)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;   // 100 ns period
   end

   // driving and most sampling happen 1 ns past the rising edge
   task automatic next_cycle();
      @(posedge clk_i);
      #1;
   endtask

   task automatic check_sample(string what, sample_t got, sample_t exp);
      checks++;
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_data(string what, bus_data_t got, bus_data_t exp);
      checks++;
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(string what, logic got, logic exp);
      checks++;
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   function automatic logic [16:0] lfsr_next(logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   // one lfsr step per bit and sign extension from the top bit taken
   function automatic sample_t random_sample(int bits);
      int v;
      v = 0;
      for (int b = 0; b < bits; b++) begin
         lfsr = lfsr_next(lfsr);
         v = (v << 1) | int'(lfsr[0]);
      end
      if (v >= (1 << (bits - 1))) begin
         v = v - (1 << bits);
      end
      return sample_t'(v);
   endfunction

   // plain sum of every direct input whose mask bit for this dac is set
   function automatic int direct_sum(int ch);
      int s;
      s = 0;
      for (int k = 0; k < N_SLOTS; k++) begin
         if (mask_model[k][ch]) s += int'(slot_direct[k]);
      end
      if (mask_model[N_SLOTS][ch]) s += int'(asg1);
      if (mask_model[N_SLOTS+1][ch]) s += int'(asg2);
      return s;
   endfunction

   function automatic logic out_of_range(int s);
      return (s > (1 << 13) - 1) || (s < -(1 << 13));   // 14-bit signed range
   endfunction

   function automatic sample_t clamp_sum(int s);
      if (s > (1 << 13) - 1) return sample_t'((1 << 13) - 1);
      else if (s < -(1 << 13)) return sample_t'(-(1 << 13));
      else return sample_t'(s);
   endfunction

   function automatic bus_addr_t make_addr(int tgt, logic [31:0] ofs);
      return (bus_addr_t'(tgt[TGT_W-1:0]) << TGT_LSB) | bus_addr_t'(ofs[OFS_W-1:0]);
   endfunction

   function automatic sample_t consumer_out(int c);
      if (c < N_SLOTS) return slot_in[c];
      else if (c == CON_SCOPE1) return scope1;
      else if (c == CON_SCOPE2) return scope2;
      else if (c == CON_PWM0) return pwm0;
      else return pwm1;
   endfunction

   // one strobe cycle and then a poll for the ack
   task automatic bus_access(logic write, bus_addr_t addr, bus_data_t wdata,
                             output bus_data_t rdata);
      int waited;
      sys_req = '{addr: addr, wdata: wdata, wen: write, ren: !write};
      next_cycle();
      sys_req.wen = 1'b0;
      sys_req.ren = 1'b0;
      waited = 1;
      while (!sys_rsp.ack && waited < ACK_TIMEOUT) begin
         next_cycle();
         waited++;
      end
      rdata = sys_rsp.rdata;
      if (!sys_rsp.ack) begin
         failures++;
         timed_out = 1'b1;
         $display("no bus acknowledge within %0d cycles for address %h", ACK_TIMEOUT, addr);
      end else begin
         check_flag("acknowledge one cycle after strobe", waited == 1, 1'b1);
         check_flag("bus error bit", sys_rsp.err, 1'b0);
      end
   endtask

   task automatic read_expect(int tgt, logic [31:0] ofs, bus_data_t exp);
      bus_data_t rdata;
      bus_access(1'b0, make_addr(tgt, ofs), '0, rdata);
      if (!timed_out) begin
         check_data($sformatf("read %h", make_addr(tgt, ofs)), rdata, exp);
      end
   endtask

   // random direct values where the dac holds the old sum for four edges
   // and shows the new one on the fifth
   task automatic random_sums(int bits, int count);
      sample_t   old1, old2;
      int        s1, s2;
      bus_data_t flags;
      for (int i = 0; i < count && !timed_out; i++) begin
         old1 = clamp_sum(direct_sum(MASK_DAC1));
         old2 = clamp_sum(direct_sum(MASK_DAC2));
         for (int k = 0; k < N_SLOTS; k++) slot_direct[k] = random_sample(bits);
         s1 = direct_sum(MASK_DAC1);
         s2 = direct_sum(MASK_DAC2);
         repeat (SUM_LATENCY - 1) next_cycle();
         check_sample("dac1 before latency", dac_a, old1);
         check_sample("dac2 before latency", dac_b, old2);
         next_cycle();
         check_sample("dac1 random sum", dac_a, clamp_sum(s1));
         check_sample("dac2 random sum", dac_b, clamp_sum(s2));
         bus_access(1'b0, make_addr(0, OFS_SAT), '0, flags);
         check_flag("dac1 saturation flag", flags[0], out_of_range(s1));
         check_flag("dac2 saturation flag", flags[1], out_of_range(s2));
      end
   endtask

   task automatic run_op(logic [7:0] op, logic [31:0] f0, logic [31:0] f1,
                         logic [31:0] f2, logic [31:0] f3);
      bus_data_t rdata;
      case (op)
         "W": begin
            bus_access(1'b1, make_addr(int'(f0), f1), f2, rdata);
            if (f1[OFS_W-1:0] == OFS_OUTPUT_SEL && f0 < N_DIRECT) begin
               mask_model[f0[3:0]] = f2[1:0];
            end
         end
         "R": read_expect(int'(f0), f1, f2);
         "B": begin
            for (int t = int'(f0); t <= int'(f1) && !timed_out; t++) begin
               read_expect(t, f2, f3);
            end
         end
         "A": begin
            adc_a = f0[13:0];
            adc_b = f1[13:0];
            asg1  = f2[13:0];
            asg2  = f3[13:0];
         end
         "S": begin
            slot_signal[f0[2:0]] = f1[13:0];
            slot_direct[f0[2:0]] = f2[13:0];
         end
         "C": begin
            @(negedge clk_i);                   // mux path has no register
            check_sample($sformatf("consumer %0d", f0), consumer_out(int'(f0)), f1[13:0]);
            next_cycle();
         end
         "Y": check_data("sync_o", bus_data_t'(sync), f0);
         "D": begin
            repeat (SUM_LATENCY) next_cycle();
            check_sample("dac1", dac_a, f0[13:0]);
            check_sample("dac2", dac_b, f1[13:0]);
         end
         "X": random_sums(int'(f0), int'(f1));
         default: begin
            failures++;
            $display("unknown operation code %h in vector file", op);
         end
      endcase
   endtask

   initial begin
      int          fd;
      string       line;
      logic [7:0]  op;
      logic [31:0] f0, f1, f2, f3;
      rstn_i      = 1'b0;
      adc_a       = '0;
      adc_b       = '0;
      asg1        = '0;
      asg2        = '0;
      slot_signal = '0;
      slot_direct = '0;
      sys_req     = '0;
      mask_model  = '0;                       // masks come out of reset cleared
      lfsr        = 17'd94377;
      timed_out   = 1'b0;
      checks      = 0;
      mismatches  = 0;
      failures    = 0;
      repeat (3) @(posedge clk_i);
      #1 rstn_i = 1'b1;
      fd = $fopen("dsp_vectors.txt", "r");
      if (fd == 0) begin
         failures++;
         $display("could not open dsp_vectors.txt");
      end else begin
         while (!timed_out && $fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") continue;   // blank or comment
            f0 = '0;
            f1 = '0;
            f2 = '0;
            f3 = '0;
            void'($sscanf(line, "%c %h %h %h %h", op, f0, f1, f2, f3));
            run_op(op, f0, f1, f2, f3);
         end
         $fclose(fd);
      end
      $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== dsp_vectors.txt ====
# op then up to four hex fields, samples are 14-bit two's complement
# W tgt ofs data | R tgt ofs exp | B first last ofs exp | A adc_a adc_b asg1 asg2
# S slot signal direct | C consumer exp | Y sync exp | D dac1 dac2 | X bits count
B 0 7 0 a
R 8 0 a
R 9 0 b
B a b 0 f
B 0 9 4 0
R 0 c ff
Y ff
D 0 0
C a 0
C b 0
R 0 8 0
A 0123 3f00 0456 0789
S 3 0abc 0000
C 0 0123
C 9 3f00
W 8 0 3
C 8 0abc
W a 0 8
C a 0456
W b 0 b
C b 3f00
W 8 0 e
C 8 0
S 0 0000 0100
S 1 0000 0200
S 7 0000 3f00
W 0 4 1
W 1 4 3
W 7 4 2
W 8 4 1
D 0756 0100
W 4 0 c
C 4 0756
W 9 0 d
C 9 0100
R b 10 3f00
S 0 0000 1fff
S 1 0000 1fff
D 1fff 1eff
R 0 8 1
S 1 0000 2000
S 7 0000 2000
D 0455 2000
R 0 8 2
S 0 0000 2000
D 2000 2000
R 0 8 3
S 0 0000 0000
S 1 0000 0000
S 7 0000 0000
D 0456 0000
R 0 8 0
W 0 c a5
R 0 c a5
Y a5
W 0 20 ffffffff
R 0 20 0
W 2 4 3
W 3 4 1
W 4 4 2
W 5 4 3
W 9 4 2
D 0456 0789
X c 6
X e 3

// ==== flist.f ====
dsp_route_pkg.sv
dsp_bus_pkg.sv
dsp_source_mux.sv
dsp_dac_sum.sv
dsp_route_regs.sv
red_pitaya_dsp.sv
tb_dsp.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_dsp with verilator, run it into sim.log, check the result"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/Vtb_dsp: flist.f *.sv
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_dsp -f flist.f

test: obj_dir/Vtb_dsp
	./obj_dir/Vtb_dsp > sim.log
	@cat sim.log
	@grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
